// ==== wb_bridge_pkg.sv ====
`default_nettype none

package wb_bridge_pkg;

  // bus geometry, fixed at a 64-bit data path
  localparam int data_width_gp    = 64;
  localparam int sel_width_gp     = data_width_gp / 8;
  localparam int sel_width_log_gp = $clog2(sel_width_gp);
  localparam int paddr_width_gp   = 32;

  typedef enum logic [0:0] {
    e_mem_uc_rd = 1'b0,
    e_mem_uc_wr = 1'b1
  } msg_type_e;

  // encoded value is log2 of the byte count
  typedef enum logic [1:0] {
    e_size_1 = 2'd0,
    e_size_2 = 2'd1,
    e_size_4 = 2'd2,
    e_size_8 = 2'd3
  } msg_size_e;

  typedef struct packed {
    msg_type_e                 msg_type;
    msg_size_e                 size;
    logic [paddr_width_gp-1:0] addr;
    logic [data_width_gp-1:0]  data;
  } mem_cmd_s;

  typedef struct packed {
    msg_type_e                 msg_type;
    msg_size_e                 size;
    logic [paddr_width_gp-1:0] addr;
    logic [data_width_gp-1:0]  data;
  } mem_rsp_s;

  typedef struct packed {
    logic [paddr_width_gp-sel_width_log_gp-1:0] adr;
    logic [data_width_gp-1:0]                   dat;
    logic [sel_width_gp-1:0]                    sel;
    logic                                       we;
    mem_cmd_s                                   cmd;
  } wb_req_s;

  // copy the low bytes of a word across all lanes
  function automatic logic [data_width_gp-1:0] replicate_data(
    input logic [data_width_gp-1:0] d,
    input msg_size_e                s
  );
    case (s)
      e_size_1: replicate_data = {8{d[7:0]}};
      e_size_2: replicate_data = {4{d[15:0]}};
      e_size_4: replicate_data = {2{d[31:0]}};
      default:  replicate_data = d;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== mem_cmd_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_cmd_decode (
  input  wire logic                 clk_i,
  input  wire logic                 rst_i,

  input  wire wb_bridge_pkg::mem_cmd_s cmd_i,
  input  wire logic                 cmd_v_i,
  output logic                      cmd_ready_o,

  output wb_bridge_pkg::wb_req_s    req_o,
  output logic                      req_v_o,
  input  wire logic                 req_yumi_i
);

  import wb_bridge_pkg::*;

  mem_cmd_s                    cmd_r;
  logic                        cmd_v_r;
  logic                        cmd_xfer;
  logic [sel_width_log_gp-1:0] byte_offset;
  logic [sel_width_gp-1:0]     sel_mask;

  // accept a new command when empty or when the held one leaves this cycle
  assign cmd_ready_o = ~cmd_v_r | req_yumi_i;
  assign cmd_xfer    = cmd_v_i & cmd_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cmd_v_r <= 1'b0;
    end else if (cmd_xfer) begin
      cmd_v_r <= 1'b1;
    end else if (req_yumi_i) begin
      cmd_v_r <= 1'b0;
    end
  end

  // payload holding register
  always_ff @(posedge clk_i) begin
    if (cmd_xfer) begin
      cmd_r <= cmd_i;
    end
  end

  assign byte_offset = cmd_r.addr[sel_width_log_gp-1:0];

  // lane mask before shifting to the addressed offset
  always_comb begin
    case (cmd_r.size)
      e_size_1: sel_mask = 8'h01;
      e_size_2: sel_mask = 8'h03;
      e_size_4: sel_mask = 8'h0f;
      default:  sel_mask = 8'hff;
    endcase
  end

  always_comb begin
    req_o.adr = cmd_r.addr[paddr_width_gp-1:sel_width_log_gp];
    req_o.sel = sel_mask << byte_offset;
    req_o.we  = (cmd_r.msg_type == e_mem_uc_wr);
    req_o.cmd = cmd_r;
    // reads leave the write bus quiet
    if (cmd_r.msg_type == e_mem_uc_wr) begin
      req_o.dat = replicate_data(cmd_r.data, cmd_r.size);
    end else begin
      req_o.dat = '0;
    end
  end

  assign req_v_o = cmd_v_r;

endmodule

`default_nettype wire

// ==== wb_cycle_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_cycle_exec #(
  parameter int return_fifo_els_p = 4
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,

  input  wire wb_bridge_pkg::wb_req_s req_i,
  input  wire logic                  req_v_i,
  output logic                       req_yumi_o,
  input  wire logic                  rsp_pop_i,

  output logic [wb_bridge_pkg::paddr_width_gp-wb_bridge_pkg::sel_width_log_gp-1:0] adr_o,
  output logic [wb_bridge_pkg::data_width_gp-1:0] dat_o,
  output logic [wb_bridge_pkg::sel_width_gp-1:0]  sel_o,
  output logic                       we_o,
  output logic                       cyc_o,
  output logic                       stb_o,
  input  wire logic                  ack_i,

  output logic                       done_o,
  output wb_bridge_pkg::wb_req_s     done_req_o
);

  import wb_bridge_pkg::*;

  localparam int credit_width_lp = $clog2(return_fifo_els_p + 1);

  typedef enum logic [0:0] {
    e_idle = 1'b0,
    e_busy = 1'b1
  } exec_state_e;

  exec_state_e                state_r;
  wb_req_s                    req_r;
  logic [credit_width_lp-1:0] credit_cnt_r;
  logic                       start;

  // a cycle only starts if its response is sure to fit in the return fifo
  assign start      = (state_r == e_idle) & req_v_i
                    & (credit_cnt_r < credit_width_lp'(return_fifo_els_p));
  assign req_yumi_o = start;
  assign done_o     = (state_r == e_busy) & ack_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= e_idle;
    end else if (start) begin
      state_r <= e_busy;
    end else if (done_o) begin
      state_r <= e_idle;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      req_r <= req_i;
    end
  end

  // responses issued but not yet taken by the consumer
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      credit_cnt_r <= '0;
    end else if (start & ~rsp_pop_i) begin
      credit_cnt_r <= credit_cnt_r + 1'b1;
    end else if (~start & rsp_pop_i) begin
      credit_cnt_r <= credit_cnt_r - 1'b1;
    end
  end

  assign cyc_o      = (state_r == e_busy);
  assign stb_o      = (state_r == e_busy);
  assign adr_o      = req_r.adr;
  assign dat_o      = req_r.dat;
  assign sel_o      = req_r.sel;
  assign we_o       = req_r.we;
  assign done_req_o = req_r;

endmodule

`default_nettype wire

// ==== rsp_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module rsp_fifo #(
  parameter int els_p = 4
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,

  input  wire wb_bridge_pkg::mem_rsp_s data_i,
  input  wire logic                   v_i,

  output wb_bridge_pkg::mem_rsp_s     data_o,
  output logic                        v_o,
  input  wire logic                   yumi_i
);

  import wb_bridge_pkg::*;

  localparam int ptr_width_lp = $clog2(els_p);
  localparam int cnt_width_lp = $clog2(els_p + 1);

  mem_rsp_s                 mem_r [els_p];
  logic [ptr_width_lp-1:0]  wr_ptr_r;
  logic [ptr_width_lp-1:0]  rd_ptr_r;
  logic [cnt_width_lp-1:0]  count_r;

  // pointers wrap explicitly so any depth works
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (v_i) begin
        wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(els_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (yumi_i) begin
        rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(els_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      if (v_i & ~yumi_i) begin
        count_r <= count_r + 1'b1;
      end else if (~v_i & yumi_i) begin
        count_r <= count_r - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  assign data_o = mem_r[rd_ptr_r];
  assign v_o    = (count_r != '0);

endmodule

`default_nettype wire

// ==== rsp_data_pack.sv ====
`timescale 1ns/1ps
`default_nettype none

module rsp_data_pack #(
  parameter int return_fifo_els_p = 4,
  parameter int paddr_width_p     = wb_bridge_pkg::paddr_width_gp
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,

  input  wire logic                  done_i,
  input  wire wb_bridge_pkg::wb_req_s done_req_i,
  input  wire logic [wb_bridge_pkg::data_width_gp-1:0] dat_i,

  output wb_bridge_pkg::mem_rsp_s    rsp_o,
  output logic                       rsp_v_o,
  input  wire logic                  rsp_ready_i,
  output logic                       rsp_pop_o
);

  import wb_bridge_pkg::*;

  logic [paddr_width_p-1:0]    addr_li;
  logic [sel_width_log_gp-1:0] byte_offset;
  logic [data_width_gp-1:0]    dat_shifted;
  mem_rsp_s                    rsp_li;

  assign addr_li     = done_req_i.cmd.addr;
  assign byte_offset = addr_li[sel_width_log_gp-1:0];

  // bring the addressed bytes down to lane zero
  assign dat_shifted = dat_i >> {byte_offset, 3'b000};

  always_comb begin
    rsp_li.msg_type = done_req_i.cmd.msg_type;
    rsp_li.size     = done_req_i.cmd.size;
    rsp_li.addr     = done_req_i.cmd.addr;
    if (done_req_i.cmd.msg_type == e_mem_uc_rd) begin
      rsp_li.data = replicate_data(dat_shifted, done_req_i.cmd.size);
    end else begin
      rsp_li.data = '0;
    end
  end

  assign rsp_pop_o = rsp_v_o & rsp_ready_i;

  // space is guaranteed by the credit counter in execute
  rsp_fifo #(
    .els_p (return_fifo_els_p)
  ) return_fifo (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .data_i (rsp_li),
    .v_i    (done_i),
    .data_o (rsp_o),
    .v_o    (rsp_v_o),
    .yumi_i (rsp_pop_o)
  );

endmodule

`default_nettype wire

// ==== wb_master_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_master_bridge #(
  parameter int paddr_width_p     = wb_bridge_pkg::paddr_width_gp,
  parameter int return_fifo_els_p = 4
) (
  input  wire logic                    clk_i,
  input  wire logic                    rst_i,

  // command stream
  input  wire wb_bridge_pkg::mem_cmd_s cmd_i,
  input  wire logic                    cmd_v_i,
  output logic                         cmd_ready_o,

  // response stream
  output wb_bridge_pkg::mem_rsp_s      rsp_o,
  output logic                         rsp_v_o,
  input  wire logic                    rsp_ready_i,

  // wishbone master
  output logic [paddr_width_p-wb_bridge_pkg::sel_width_log_gp-1:0] adr_o,
  output logic [wb_bridge_pkg::data_width_gp-1:0] dat_o,
  output logic [wb_bridge_pkg::sel_width_gp-1:0]  sel_o,
  output logic                         we_o,
  output logic                         cyc_o,
  output logic                         stb_o,
  input  wire logic [wb_bridge_pkg::data_width_gp-1:0] dat_i,
  input  wire logic                    ack_i
);

  import wb_bridge_pkg::*;

  wb_req_s req_lo;
  logic    req_v_lo;
  logic    req_yumi_lo;
  logic    done_lo;
  wb_req_s done_req_lo;
  logic    rsp_pop_lo;

  mem_cmd_decode decode (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_i       (cmd_i),
    .cmd_v_i     (cmd_v_i),
    .cmd_ready_o (cmd_ready_o),
    .req_o       (req_lo),
    .req_v_o     (req_v_lo),
    .req_yumi_i  (req_yumi_lo)
  );

  wb_cycle_exec #(
    .return_fifo_els_p (return_fifo_els_p)
  ) exec (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .req_i      (req_lo),
    .req_v_i    (req_v_lo),
    .req_yumi_o (req_yumi_lo),
    .rsp_pop_i  (rsp_pop_lo),
    .adr_o      (adr_o),
    .dat_o      (dat_o),
    .sel_o      (sel_o),
    .we_o       (we_o),
    .cyc_o      (cyc_o),
    .stb_o      (stb_o),
    .ack_i      (ack_i),
    .done_o     (done_lo),
    .done_req_o (done_req_lo)
  );

  rsp_data_pack #(
    .return_fifo_els_p (return_fifo_els_p),
    .paddr_width_p     (paddr_width_p)
  ) result (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .done_i      (done_lo),
    .done_req_i  (done_req_lo),
    .dat_i       (dat_i),
    .rsp_o       (rsp_o),
    .rsp_v_o     (rsp_v_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_pop_o   (rsp_pop_lo)
  );

endmodule

`default_nettype wire

// ==== wb_slave_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_slave_model (
  input  wire logic        clk_i,
  input  wire logic        rst_i,
  input  wire logic [28:0] adr_i,
  input  wire logic [63:0] dat_i,
  input  wire logic [7:0]  sel_i,
  input  wire logic        we_i,
  input  wire logic        cyc_i,
  input  wire logic        stb_i,
  output logic [63:0]      dat_o,
  output logic             ack_o
);

  logic [63:0] mem [256];
  logic [63:0] wmask;
  logic [1:0]  wait_cnt;

  assign wmask = {{8{sel_i[7]}}, {8{sel_i[6]}}, {8{sel_i[5]}}, {8{sel_i[4]}},
                  {8{sel_i[3]}}, {8{sel_i[2]}}, {8{sel_i[1]}}, {8{sel_i[0]}}};

  // memory refill during reset gives every word a distinct value
  always @(posedge clk_i) begin
    if (rst_i) begin
      ack_o    <= 1'b0;
      dat_o    <= '0;
      wait_cnt <= 2'($urandom % 4);
      for (int i = 0; i < 256; i++) begin
        mem[i[7:0]] <= {8{i[7:0]}} ^ 64'h0123_4567_89ab_cdef;
      end
    end else if (ack_o) begin
      // drop ack after one cycle and pick the next delay
      ack_o    <= 1'b0;
      wait_cnt <= 2'($urandom % 4);
    end else if (cyc_i && stb_i) begin
      if (wait_cnt == 2'd0) begin
        ack_o <= 1'b1;
        dat_o <= mem[adr_i[7:0]];
        if (we_i) begin
          mem[adr_i[7:0]] <= (mem[adr_i[7:0]] & ~wmask) | (dat_i & wmask);
        end
      end else begin
        wait_cnt <= wait_cnt - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== wb_bridge_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_bridge_checker (
  input wire logic                    clk_i,
  input wire logic                    rst_i,
  input wire wb_bridge_pkg::mem_cmd_s cmd_i,
  input wire logic                    cmd_v_i,
  input wire logic [7:0]              sel_i,
  input wire logic                    cyc_i,
  input wire logic                    stb_i,
  input wire logic                    ack_i
);

  int fail_cnt = 0;

  a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i) stb_i |-> cyc_i)
    else begin
      $error("stb_o high outside a cycle");
      fail_cnt++;
    end

  a_sel_nonzero: assert property (@(posedge clk_i) disable iff (rst_i)
    stb_i |-> (sel_i != 8'h00))
    else begin
      $error("strobe with no byte lane selected");
      fail_cnt++;
    end

  // low address bits below the size must be zero
  a_cmd_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
    cmd_v_i |-> ((cmd_i.addr[2:0] & ~(3'b111 << cmd_i.size)) == 3'b000))
    else begin
      $error("command address not aligned to its size");
      fail_cnt++;
    end

  a_cyc_until_ack: assert property (@(posedge clk_i) disable iff (rst_i)
    (cyc_i && !ack_i) |=> cyc_i)
    else begin
      $error("cycle dropped before ack");
      fail_cnt++;
    end

endmodule

bind wb_master_bridge wb_bridge_checker bridge_checker (
  .clk_i   (clk_i),
  .rst_i   (rst_i),
  .cmd_i   (cmd_i),
  .cmd_v_i (cmd_v_i),
  .sel_i   (sel_o),
  .cyc_i   (cyc_o),
  .stb_i   (stb_o),
  .ack_i   (ack_i)
);

`default_nettype wire

// ==== tb_wb_master_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_wb_master_bridge;

  import wb_bridge_pkg::*;

  localparam int timeout_cycles_lp = 200;
  localparam int bp_stall_lp       = 40;

  typedef struct packed {
    msg_type_e   op;
    msg_size_e   size;
    logic [31:0] addr;
    logic [63:0] wdata;
    logic [63:0] exp_data;
    logic [7:0]  stall;
  } test_row_s;

  logic        clk = 1'b0;
  logic        rst;
  mem_cmd_s    cmd;
  logic        cmd_v;
  logic        cmd_ready;
  mem_rsp_s    rsp;
  logic        rsp_v;
  logic        rsp_ready;
  logic [28:0] wb_adr;
  logic [63:0] wb_dat_w;
  logic [63:0] wb_dat_r;
  logic [7:0]  wb_sel;
  logic        wb_we;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_ack;

  test_row_s   rows[$];
  string       names[$];
  logic [63:0] ref_mem [256];
  int          errors;
  int          tests_run;
  logic        timed_out;

  always #10 clk = ~clk;

  wb_master_bridge #(
    .paddr_width_p     (32),
    .return_fifo_els_p (4)
  ) wb_master_bridge_i (
    .clk_i       (clk),
    .rst_i       (rst),
    .cmd_i       (cmd),
    .cmd_v_i     (cmd_v),
    .cmd_ready_o (cmd_ready),
    .rsp_o       (rsp),
    .rsp_v_o     (rsp_v),
    .rsp_ready_i (rsp_ready),
    .adr_o       (wb_adr),
    .dat_o       (wb_dat_w),
    .sel_o       (wb_sel),
    .we_o        (wb_we),
    .cyc_o       (wb_cyc),
    .stb_o       (wb_stb),
    .dat_i       (wb_dat_r),
    .ack_i       (wb_ack)
  );

  wb_slave_model slave (
    .clk_i (clk),
    .rst_i (rst),
    .adr_i (wb_adr),
    .dat_i (wb_dat_w),
    .sel_i (wb_sel),
    .we_i  (wb_we),
    .cyc_i (wb_cyc),
    .stb_i (wb_stb),
    .dat_o (wb_dat_r),
    .ack_o (wb_ack)
  );

  // reference memory: byte lanes updated one at a time
  function automatic logic [63:0] ref_access(msg_type_e op, msg_size_e size,
                                             logic [31:0] addr, logic [63:0] wdata);
    int          nbytes;
    int          off;
    int          src;
    logic [7:0]  idx;
    logic [63:0] word;
    logic [63:0] lane;
    logic [63:0] result;
    nbytes = 1 << size;
    off    = int'(addr[2:0]);
    idx    = addr[10:3];
    word   = ref_mem[idx];
    result = '0;
    for (int b = 0; b < 8; b++) begin
      src = b % nbytes;
      if (op == e_mem_uc_wr) begin
        if (b >= off && b < off + nbytes) begin
          lane = (wdata >> (src * 8)) & 64'hff;
          word = (word & ~(64'hff << (b * 8))) | (lane << (b * 8));
        end
      end else begin
        lane   = (word >> ((off + src) * 8)) & 64'hff;
        result = result | (lane << (b * 8));
      end
    end
    ref_mem[idx] = word;
    return result;
  endfunction

  task automatic add_row(string name, msg_type_e op, msg_size_e size,
                         logic [31:0] addr, logic [63:0] wdata, int stall);
    test_row_s row;
    row.op       = op;
    row.size     = size;
    row.addr     = addr;
    row.wdata    = wdata;
    row.exp_data = ref_access(op, size, addr, wdata);
    row.stall    = 8'(stall);
    rows.push_back(row);
    names.push_back(name);
  endtask

  task automatic add_random_rows(int count);
    msg_size_e   size;
    logic [31:0] addr;
    for (int n = 0; n < count; n++) begin
      size = msg_size_e'($urandom % 4);
      addr = 32'h100 + ($urandom % 32'h80);
      addr = addr & ~((32'd1 << size) - 32'd1);
      add_row($sformatf("rand_%0d", n), msg_type_e'($urandom % 2), size, addr,
              {$urandom, $urandom}, int'($urandom % 3));
    end
  endtask

  task automatic check_rsp(string name, mem_rsp_s exp, mem_rsp_s act);
    if (act !== exp) begin
      $display("** Error: %s expected type/size/addr/data %0d/%0d/%h/%h, actual %0d/%0d/%h/%h",
               name, exp.msg_type, exp.size, exp.addr, exp.data,
               act.msg_type, act.size, act.addr, act.data);
      errors++;
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("** Error: %s expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic send_commands();
    int waited;
    for (int i = 0; i < rows.size() && !timed_out; i++) begin
      @(negedge clk);
      cmd.msg_type = rows[i].op;
      cmd.size     = rows[i].size;
      cmd.addr     = rows[i].addr;
      cmd.data     = rows[i].wdata;
      cmd_v        = 1'b1;
      waited       = 0;
      while (!cmd_ready && !timed_out) begin
        @(negedge clk);
        waited++;
        if (waited > timeout_cycles_lp) begin
          $display("timeout: command %s was never accepted", names[i]);
          timed_out = 1'b1;
        end
      end
    end
    @(negedge clk);
    cmd_v = 1'b0;
  endtask

  task automatic collect_responses();
    mem_rsp_s exp;
    int       waited;
    int       errors_before;
    for (int i = 0; i < rows.size() && !timed_out; i++) begin
      errors_before = errors;
      if (rows[i].stall != 8'd0) begin
        rsp_ready = 1'b0;
        repeat (rows[i].stall) @(negedge clk);
        // fifo full, execute blocked, decode holding: ready must be low
        if (rows[i].stall >= 8'(bp_stall_lp)) begin
          check_bit({names[i], " cmd_ready_o"}, 1'b0, cmd_ready);
        end
      end
      rsp_ready = 1'b1;
      waited    = 0;
      while (!rsp_v && !timed_out) begin
        @(negedge clk);
        waited++;
        if (waited > timeout_cycles_lp) begin
          $display("timeout: no response arrived for %s", names[i]);
          timed_out = 1'b1;
        end
      end
      if (!timed_out) begin
        exp.msg_type = rows[i].op;
        exp.size     = rows[i].size;
        exp.addr     = rows[i].addr;
        exp.data     = rows[i].exp_data;
        check_rsp(names[i], exp, rsp);
        tests_run++;
        $display("test %s: %s", names[i], (errors == errors_before) ? "ok" : "failed");
        @(negedge clk);
      end
    end
  endtask

  initial begin
    void'($urandom(32'he4e9_2337));
    rst       = 1'b1;
    cmd       = '0;
    cmd_v     = 1'b0;
    rsp_ready = 1'b0;
    errors    = 0;
    tests_run = 0;
    timed_out = 1'b0;
    for (int i = 0; i < 256; i++) begin
      ref_mem[i[7:0]] = {8{i[7:0]}} ^ 64'h0123_4567_89ab_cdef;
    end

    add_row("wr8_full", e_mem_uc_wr, e_size_8, 32'h40, 64'hdead_beef_cafe_f00d, 0);
    add_row("rd8_full", e_mem_uc_rd, e_size_8, 32'h40, 64'h0, 0);
    add_row("wr1_lane5", e_mem_uc_wr, e_size_1, 32'h85, 64'h1122_3344_5566_773c, 0);
    add_row("wr2_lane2", e_mem_uc_wr, e_size_2, 32'h82, 64'h99aa_bbcc_ddee_a5b6, 0);
    add_row("rd8_merged", e_mem_uc_rd, e_size_8, 32'h80, 64'h0, 0);
    add_row("rd1_off3", e_mem_uc_rd, e_size_1, 32'h43, 64'h0, 0);
    add_row("rd2_off6", e_mem_uc_rd, e_size_2, 32'h46, 64'h0, 0);
    add_row("rd4_off4", e_mem_uc_rd, e_size_4, 32'h44, 64'h0, 0);
    add_row("rd4_fill", e_mem_uc_rd, e_size_4, 32'h10c, 64'h0, 0);
    add_row("bp_stall", e_mem_uc_rd, e_size_8, 32'h40, 64'h0, bp_stall_lp);
    for (int n = 0; n < 8; n++) begin
      add_row($sformatf("bp_%0d", n), (n % 2 == 0) ? e_mem_uc_wr : e_mem_uc_rd,
              e_size_4, 32'h60 + 32'(n / 2) * 32'h8, 64'h5a5a_0000_0000_0000 + 64'(n), 0);
    end
    add_random_rows(24);

    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    check_bit("reset cmd_ready_o", 1'b1, cmd_ready);
    check_bit("reset rsp_v_o", 1'b0, rsp_v);
    check_bit("reset cyc_o", 1'b0, wb_cyc);
    check_bit("reset stb_o", 1'b0, wb_stb);
    tests_run++;
    $display("test reset_state: %s", (errors == 0) ? "ok" : "failed");

    fork
      send_commands();
      collect_responses();
    join

    $display("tests run %0d, failed checks %0d, assertion failures %0d", tests_run, errors,
             wb_master_bridge_i.bridge_checker.fail_cnt);
    if (timed_out || errors != 0 || wb_master_bridge_i.bridge_checker.fail_cnt != 0) begin
      $display("RESULT: FAIL");
    end else begin
      $display("RESULT: PASS");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
wb_bridge_pkg.sv
mem_cmd_decode.sv
wb_cycle_exec.sv
rsp_fifo.sv
rsp_data_pack.sv
wb_master_bridge.sv
wb_slave_model.sv
wb_bridge_checker.sv
tb_wb_master_bridge.sv

// ==== Makefile ====
# Verilator flow for the Wishbone master bridge

TOP := tb_wb_master_bridge

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module wb_master_bridge \
		wb_bridge_pkg.sv mem_cmd_decode.sv wb_cycle_exec.sv rsp_fifo.sv \
		rsp_data_pack.sv wb_master_bridge.sv
	verilator --lint-only --timing --assert --top-module $(TOP) -f verilog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f verilog.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee /dev/stderr | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir
